// ==== common/dac_cfg_config.svh ====
`ifndef DAC_CFG_CONFIG_SVH
`define DAC_CFG_CONFIG_SVH

// i2c master core register map
`define DAC_REG_PRE_LO    3'd0
`define DAC_REG_PRE_HI    3'd1
`define DAC_REG_CTR       3'd2
`define DAC_REG_TXR_RXR   3'd3    // txr on write, rxr on read
`define DAC_REG_CR_SR     3'd4    // cr on write, sr on read

// command register bits
`define DAC_CR_STA        8'h80
`define DAC_CR_STO        8'h40
`define DAC_CR_RD         8'h20
`define DAC_CR_WR         8'h10
`define DAC_CR_NACK       8'h08
`define DAC_CR_IACK       8'h01

`define DAC_CTR_ENABLE    8'hC0   // core enable + irq enable
`define DAC_SR_TIP_BIT    7

// ad5339 pointer byte
`define DAC_POINTER       8'h01

`define DAC_DATA_WIDTH    16

// scl = sys_clk / (5 * (prescale + 1))
`define DAC_SYS_CLK_MHZ   20
`define DAC_SCL_KHZ       100
`define DAC_PRESCALE      (16'((`DAC_SYS_CLK_MHZ * 1000) / (5 * `DAC_SCL_KHZ) - 1))

// queue depth, also the sequencer's starting credits
`define DAC_CMD_DEPTH     4

`endif

// ==== common/dac_cfg_pkg.sv ====
`include "dac_cfg_config.svh"

package dac_cfg_pkg;

    // what the wishbone engine does with one queue entry
    typedef enum logic [1:0] {
        OP_REG_WR   = 2'd0,    // single wishbone write
        OP_REG_RD   = 2'd1,    // single wishbone read, data comes back as a response
        OP_WAIT_SET = 2'd2,    // hold until the core irq goes high
        OP_WAIT_CLR = 2'd3     // hold until the core irq goes low
    } wb_op_e;

    // sequencer -> engine
    typedef struct packed {
        wb_op_e      op;
        logic [2:0]  addr;
        logic [7:0]  data;     // unused for reads and waits
    } wb_cmd_t;

    // engine -> sequencer, one pulse per register read
    typedef struct packed {
        logic        valid;
        logic [7:0]  data;
    } wb_rsp_t;

    // outgoing wishbone signals
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [7:0]  dat;
    } wb_bus_t;

    // request control -> sequencer
    // fields other than start stay stable for the whole job
    typedef struct packed {
        logic                        start;
        logic                        is_read;
        logic [6:0]                  dev_addr;
        logic [`DAC_DATA_WIDTH-1:0]  wr_data;
    } host_job_t;

endpackage

// ==== dac_seq/dac_seq_fsm.sv ====
`timescale 1ns/10ps
`include "dac_cfg_config.svh"

module dac_seq_fsm import dac_cfg_pkg::*; (
    input  logic                        sys_clk,
    input  logic                        sys_rst,
    input  host_job_t                   job_i,
    output logic                        job_done_o,
    output logic [`DAC_DATA_WIDTH-1:0]  rd_word_o,
    output wb_cmd_t                     cmd_o,
    output logic                        cmd_valid_o,
    input  logic                        credit_return_i,
    input  wb_rsp_t                     rsp_i
);

localparam int          CW       = $clog2(`DAC_CMD_DEPTH + 1);
localparam logic [15:0] PRESCALE = `DAC_PRESCALE;

localparam logic [2:0] S_IDLE = 3'd0;
localparam logic [2:0] S_INIT = 3'd1;   // prescaler and ctr writes
localparam logic [2:0] S_TX   = 3'd2;
localparam logic [2:0] S_RX   = 3'd3;
localparam logic [2:0] S_DONE = 3'd4;

logic [2:0]    state;
logic [2:0]    sub;         // step inside the current byte
logic [2:0]    byte_idx;    // rx bytes follow the tx bytes
logic [2:0]    last_tx;
logic [CW-1:0] credit_cnt;
logic          rd_pending;
logic          want;
logic          issue;
logic [7:0]    tx_byte;
logic [7:0]    tx_cr;
logic [7:0]    rx_cr;
logic [7:0]    rx_hi;
wb_cmd_t       nxt_cmd;

function automatic wb_cmd_t mk_cmd(input wb_op_e op, input logic [2:0] addr,
                                   input logic [7:0] data);
    wb_cmd_t c;
    c.op   = op;
    c.addr = addr;
    c.data = data;
    return c;
endfunction

assign last_tx = job_i.is_read ? 3'd2 : 3'd3;
assign rx_cr   = (byte_idx == 3'd3) ? `DAC_CR_RD : (`DAC_CR_RD | `DAC_CR_NACK | `DAC_CR_STO);

always_comb begin
    tx_byte = {job_i.dev_addr, 1'b0};
    tx_cr   = `DAC_CR_STA | `DAC_CR_WR;
    case (byte_idx)
        3'd1: begin
            tx_byte = `DAC_POINTER;
            tx_cr   = `DAC_CR_WR;
        end
        3'd2: begin
            tx_byte = job_i.is_read ? {job_i.dev_addr, 1'b1} : job_i.wr_data[15:8];
            tx_cr   = job_i.is_read ? (`DAC_CR_STA | `DAC_CR_WR) : `DAC_CR_WR;
        end
        3'd3: begin
            tx_byte = job_i.wr_data[7:0];
            tx_cr   = `DAC_CR_STO | `DAC_CR_WR;
        end
        default: begin
            tx_byte = {job_i.dev_addr, 1'b0};   // address with w
            tx_cr   = `DAC_CR_STA | `DAC_CR_WR;
        end
    endcase
end

always_comb begin
    want    = 1'b1;
    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_PRE_LO, PRESCALE[7:0]);
    case (state)
        S_INIT: begin
            case (sub)
                3'd0:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_PRE_LO, PRESCALE[7:0]);
                3'd1:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_PRE_HI, PRESCALE[15:8]);
                default: nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_CTR, `DAC_CTR_ENABLE);
            endcase
        end
        S_TX: begin
            case (sub)
                3'd0:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_TXR_RXR, tx_byte);
                3'd1:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_CR_SR, tx_cr);
                3'd2:    nxt_cmd = mk_cmd(OP_WAIT_SET, `DAC_REG_CR_SR, 8'h00);
                3'd3:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_CR_SR, `DAC_CR_IACK);
                3'd4:    nxt_cmd = mk_cmd(OP_WAIT_CLR, `DAC_REG_CR_SR, 8'h00);
                default: nxt_cmd = mk_cmd(OP_REG_RD, `DAC_REG_CR_SR, 8'h00);  // sr poll
            endcase
        end
        S_RX: begin
            case (sub)
                3'd0:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_CR_SR, rx_cr);
                3'd1:    nxt_cmd = mk_cmd(OP_WAIT_SET, `DAC_REG_CR_SR, 8'h00);
                3'd2:    nxt_cmd = mk_cmd(OP_REG_WR, `DAC_REG_CR_SR, `DAC_CR_IACK);
                3'd3:    nxt_cmd = mk_cmd(OP_WAIT_CLR, `DAC_REG_CR_SR, 8'h00);
                default: nxt_cmd = mk_cmd(OP_REG_RD, `DAC_REG_TXR_RXR, 8'h00);
            endcase
        end
        default: want = 1'b0;
    endcase
end

// one read in flight at most
assign issue = want & ~rd_pending & (credit_cnt != '0);

always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
        state       <= S_IDLE;
        sub         <= 3'd0;
        byte_idx    <= 3'd0;
        credit_cnt  <= CW'(`DAC_CMD_DEPTH);
        rd_pending  <= 1'b0;
        cmd_valid_o <= 1'b0;
        job_done_o  <= 1'b0;
    end else begin
        cmd_valid_o <= issue;
        job_done_o  <= 1'b0;
        credit_cnt  <= credit_cnt + CW'(credit_return_i) - CW'(issue);
        case (state)
            S_IDLE: begin
                if (job_i.start) begin
                    state    <= S_INIT;
                    sub      <= 3'd0;
                    byte_idx <= 3'd0;
                end
            end
            S_INIT: begin
                if (issue) begin
                    sub   <= (sub == 3'd2) ? 3'd0 : sub + 3'd1;
                    state <= (sub == 3'd2) ? S_TX : S_INIT;
                end
            end
            S_TX: begin
                if (issue) begin
                    if (sub == 3'd5)
                        rd_pending <= 1'b1;
                    else
                        sub <= sub + 3'd1;
                end
                if (rsp_i.valid) begin
                    rd_pending <= 1'b0;
                    if (!rsp_i.data[`DAC_SR_TIP_BIT]) begin   // byte finished once tip clears
                        sub      <= 3'd0;
                        byte_idx <= byte_idx + 3'd1;
                        if (byte_idx == last_tx)
                            state <= job_i.is_read ? S_RX : S_DONE;
                    end
                end
            end
            S_RX: begin
                if (issue) begin
                    if (sub == 3'd4)
                        rd_pending <= 1'b1;
                    else
                        sub <= sub + 3'd1;
                end
                if (rsp_i.valid) begin
                    rd_pending <= 1'b0;
                    sub        <= 3'd0;
                    byte_idx   <= byte_idx + 3'd1;
                    if (byte_idx != 3'd3)
                        state <= S_DONE;
                end
            end
            S_DONE: begin
                job_done_o <= 1'b1;
                state      <= S_IDLE;
            end
            default: state <= S_IDLE;
        endcase
    end
end

always_ff @(posedge sys_clk) begin
    if (issue)
        cmd_o <= nxt_cmd;
    if (state == S_RX && rsp_i.valid) begin
        if (byte_idx == 3'd3)
            rx_hi <= rsp_i.data;        // high byte arrives first
        else
            rd_word_o <= {rx_hi, rsp_i.data};
    end
end

a_credit_max: assert property (@(posedge sys_clk) disable iff (sys_rst)
    credit_cnt <= CW'(`DAC_CMD_DEPTH))
    else $error("credit count above queue depth");

endmodule

// ==== hw/cfg_request_ctrl.sv ====
`timescale 1ns/10ps
`include "dac_cfg_config.svh"

module cfg_request_ctrl import dac_cfg_pkg::*; (
    input  logic                        sys_clk,
    input  logic                        sys_rst,
    input  logic [6:0]                  device_addr_i,
    input  logic [`DAC_DATA_WIDTH-1:0]  iic_wr_data_i,
    input  logic                        iic_wr_req_i,
    input  logic                        iic_rd_req_i,
    output logic                        iic_wr_ack_o,
    output logic                        iic_rd_ack_o,
    output logic                        iic_wr_done_o,
    output logic                        iic_rd_done_o,
    output logic                        iic_busy_o,
    output logic [`DAC_DATA_WIDTH-1:0]  iic_rd_data_o,
    output host_job_t                   job_o,
    input  logic                        job_done_i,
    input  logic [`DAC_DATA_WIDTH-1:0]  rd_word_i
);

logic                       accept_wr;
logic                       accept_rd;
logic                       job_start;
logic                       job_is_read;    // kind of job in flight
logic [6:0]                 dev_addr_q;
logic [`DAC_DATA_WIDTH-1:0] wr_data_q;

// write has priority when both are raised
assign accept_wr = iic_wr_req_i & ~iic_busy_o;
assign accept_rd = iic_rd_req_i & ~iic_wr_req_i & ~iic_busy_o;

always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
        iic_wr_ack_o  <= 1'b0;
        iic_rd_ack_o  <= 1'b0;
        iic_wr_done_o <= 1'b0;
        iic_rd_done_o <= 1'b0;
        iic_busy_o    <= 1'b0;
        job_start     <= 1'b0;
        job_is_read   <= 1'b0;
    end else begin
        iic_wr_ack_o  <= accept_wr;
        iic_rd_ack_o  <= accept_rd;
        job_start     <= accept_wr | accept_rd;
        iic_wr_done_o <= 1'b0;
        iic_rd_done_o <= 1'b0;
        if (accept_wr | accept_rd) begin
            iic_busy_o  <= 1'b1;        // rises together with the ack
            job_is_read <= accept_rd;
        end else if (iic_busy_o && job_done_i) begin
            iic_busy_o    <= 1'b0;
            iic_wr_done_o <= ~job_is_read;
            iic_rd_done_o <= job_is_read;
        end
    end
end

// operands held steady for the sequencer
always_ff @(posedge sys_clk) begin
    if (accept_wr | accept_rd) begin
        dev_addr_q <= device_addr_i;
        wr_data_q  <= iic_wr_data_i;
    end
    if (iic_busy_o && job_done_i && job_is_read)
        iic_rd_data_o <= rd_word_i;   // kept until the next read finishes
end

assign job_o = '{start: job_start, is_read: job_is_read, dev_addr: dev_addr_q,
                 wr_data: wr_data_q};

a_busy_ends_with_done: assert property (@(posedge sys_clk) disable iff (sys_rst)
    $fell(iic_busy_o) |-> (iic_wr_done_o || iic_rd_done_o))
    else $error("busy dropped without a done pulse");

endmodule

// ==== hw/dac_cfg_top.sv ====
`timescale 1ns/10ps
`include "dac_cfg_config.svh"

module dac_cfg_top import dac_cfg_pkg::*; (
    input  logic                        sys_clk,
    input  logic                        sys_rst,

    input  logic [6:0]                  device_addr_i,
    input  logic [`DAC_DATA_WIDTH-1:0]  iic_wr_data_i,
    input  logic                        iic_wr_req_i,
    input  logic                        iic_rd_req_i,
    output logic                        iic_wr_ack_o,
    output logic                        iic_rd_ack_o,
    output logic                        iic_wr_done_o,
    output logic                        iic_rd_done_o,
    output logic                        iic_busy_o,
    output logic [`DAC_DATA_WIDTH-1:0]  iic_rd_data_o,

    // register port of the external i2c master core
    output wb_bus_t                     wb_bus_o,
    input  logic [7:0]                  wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic                        wb_intr_i
);

host_job_t                  job;
logic                       job_done;
logic [`DAC_DATA_WIDTH-1:0] rd_word;

wb_cmd_t cmd;
logic    cmd_valid;
logic    credit_return;
wb_rsp_t rsp;

cfg_request_ctrl u_cfg_request_ctrl (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .device_addr_i (device_addr_i),
    .iic_wr_data_i (iic_wr_data_i),
    .iic_wr_req_i  (iic_wr_req_i),
    .iic_rd_req_i  (iic_rd_req_i),
    .iic_wr_ack_o  (iic_wr_ack_o),
    .iic_rd_ack_o  (iic_rd_ack_o),
    .iic_wr_done_o (iic_wr_done_o),
    .iic_rd_done_o (iic_rd_done_o),
    .iic_busy_o    (iic_busy_o),
    .iic_rd_data_o (iic_rd_data_o),
    .job_o         (job),
    .job_done_i    (job_done),
    .rd_word_i     (rd_word)
);

dac_seq_fsm u_dac_seq_fsm (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .job_i           (job),
    .job_done_o      (job_done),
    .rd_word_o       (rd_word),
    .cmd_o           (cmd),
    .cmd_valid_o     (cmd_valid),
    .credit_return_i (credit_return),
    .rsp_i           (rsp)
);

wb_reg_master u_wb_reg_master (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .credit_return_o (credit_return),
    .rsp_o           (rsp),
    .wb_bus_o        (wb_bus_o),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_i        (wb_ack_i),
    .wb_intr_i       (wb_intr_i)
);

endmodule

// ==== hw/wb_reg_master.sv ====
`timescale 1ns/10ps
`include "dac_cfg_config.svh"

module wb_reg_master import dac_cfg_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  wb_cmd_t    cmd_i,
    input  logic       cmd_valid_i,
    output logic       credit_return_o,
    output wb_rsp_t    rsp_o,
    output wb_bus_t    wb_bus_o,
    input  logic [7:0] wb_dat_i,
    input  logic       wb_ack_i,
    input  logic       wb_intr_i
);

localparam int DEPTH = `DAC_CMD_DEPTH;
localparam int PW    = $clog2(DEPTH);
localparam int CW    = $clog2(DEPTH + 1);

localparam logic [1:0] E_IDLE = 2'd0;
localparam logic [1:0] E_BUS  = 2'd1;   // access on the bus, waiting for ack
localparam logic [1:0] E_WAIT = 2'd2;   // waiting on the irq level

wb_cmd_t       q_mem [DEPTH];
logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic [CW-1:0] q_cnt;
logic          pop;
logic [1:0]    eng_state;
wb_cmd_t       cur_cmd;
logic          bus_act;
logic          rsp_valid;
logic [7:0]    rsp_data;

function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign pop = (eng_state == E_IDLE) && (q_cnt != '0);

always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
        wr_ptr          <= '0;
        rd_ptr          <= '0;
        q_cnt           <= '0;
        eng_state       <= E_IDLE;
        bus_act         <= 1'b0;
        rsp_valid       <= 1'b0;
        credit_return_o <= 1'b0;
    end else begin
        credit_return_o <= pop;     // one credit back per popped entry
        rsp_valid       <= 1'b0;
        q_cnt           <= q_cnt + CW'(cmd_valid_i) - CW'(pop);
        if (cmd_valid_i)
            wr_ptr <= next_ptr(wr_ptr);
        if (pop)
            rd_ptr <= next_ptr(rd_ptr);

        case (eng_state)
            E_IDLE: begin
                if (pop) begin
                    if (q_mem[rd_ptr].op == OP_WAIT_SET || q_mem[rd_ptr].op == OP_WAIT_CLR) begin
                        eng_state <= E_WAIT;
                    end else begin
                        eng_state <= E_BUS;
                        bus_act   <= 1'b1;
                    end
                end
            end
            E_BUS: begin
                if (wb_ack_i) begin
                    bus_act   <= 1'b0;   // at least one idle cycle before the next access
                    rsp_valid <= (cur_cmd.op == OP_REG_RD);
                    eng_state <= E_IDLE;
                end
            end
            E_WAIT: begin
                if (wb_intr_i == (cur_cmd.op == OP_WAIT_SET))
                    eng_state <= E_IDLE;
            end
            default: eng_state <= E_IDLE;
        endcase
    end
end

always_ff @(posedge sys_clk) begin
    if (cmd_valid_i)
        q_mem[wr_ptr] <= cmd_i;
    if (pop)
        cur_cmd <= q_mem[rd_ptr];
    if (eng_state == E_BUS && wb_ack_i)
        rsp_data <= wb_dat_i;   // sampled with the ack
end

always_comb begin
    wb_bus_o.cyc = bus_act;
    wb_bus_o.stb = bus_act;
    wb_bus_o.we  = (cur_cmd.op == OP_REG_WR);
    wb_bus_o.adr = cur_cmd.addr;
    wb_bus_o.dat = cur_cmd.data;
end

assign rsp_o = '{valid: rsp_valid, data: rsp_data};

// credits upstream must keep the queue from overflowing
a_no_overflow: assert property (@(posedge sys_clk) disable iff (sys_rst)
    cmd_valid_i |-> q_cnt != CW'(DEPTH))
    else $error("push into a full command queue");

a_stb_until_ack: assert property (@(posedge sys_clk) disable iff (sys_rst)
    (wb_bus_o.stb && !wb_ack_i) |=> wb_bus_o.stb)
    else $error("stb dropped before ack");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dac configuration testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_dac_cfg -Mdir obj_dir

# the printed summary decides pass or fail
out=$(./obj_dir/Vtb_dac_cfg || true)
echo "$out"
echo "$out" | grep -q "TESTS PASSED"

// ==== sim/dac_cfg_checker.sv ====
`timescale 1ns/10ps
`include "dac_cfg_config.svh"

module dac_cfg_checker import dac_cfg_pkg::*; (
    input  logic        sys_clk,
    input  logic        sys_rst,
    input  logic [63:0] req_name_i,     // eight ascii characters
    input  logic [7:0]  req_rx_hi_i,
    input  logic [7:0]  req_rx_lo_i,
    input  logic [3:0]  req_tip_i,
    input  logic [6:0]  device_addr_i,
    input  logic [15:0] iic_wr_data_i,
    input  logic        iic_wr_req_i,
    input  logic        iic_rd_req_i,
    input  logic        iic_wr_ack_i,
    input  logic        iic_rd_ack_i,
    input  logic        iic_wr_done_i,
    input  logic        iic_rd_done_i,
    input  logic        iic_busy_i,
    input  logic [15:0] iic_rd_data_i,
    input  wb_bus_t     wb_bus_i,
    input  logic        wb_ack_i,
    output int          err_cnt_o,
    output int          done_cnt_o
);

// scl = clk / (5 * (prescale + 1))
localparam int PRE = (`DAC_SYS_CLK_MHZ * 1000) / (5 * `DAC_SCL_KHZ) - 1;

logic [10:0] exp_wr [32];   // {adr, dat} in bus order
int          exp_len;
int          wr_idx;
int          sr_reads;
int          rxr_reads;
int          tip;
logic        in_job;
logic        started;
logic        job_rd;
logic        prev_wr_req;
logic        prev_rd_req;
logic        have_rd;
logic [15:0] last_rd;
logic [63:0] name;
logic [7:0]  rx_hi;
logic [7:0]  rx_lo;

task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    $display("mismatch %s %s expected 0x%0h actual 0x%0h", name, what, exp_v, act_v);
    err_cnt_o++;
endtask

task automatic report_failure(input string msg);
    $display("error in %s: %s", name, msg);
    err_cnt_o++;
endtask

task automatic push_wr(input logic [2:0] adr, input logic [7:0] dat);
    exp_wr[exp_len] = {adr, dat};
    exp_len++;
endtask

// one transmitted byte: txr, command, irq acknowledge
task automatic push_tx(input logic [7:0] b, input logic [7:0] cmd);
    push_wr(`DAC_REG_TXR_RXR, b);
    push_wr(`DAC_REG_CR_SR, cmd);
    push_wr(`DAC_REG_CR_SR, `DAC_CR_IACK);
endtask

task automatic build_expected(input logic rd, input logic [6:0] dev, input logic [15:0] word);
    logic [15:0] pre;
    pre     = 16'(PRE);
    exp_len = 0;
    push_wr(`DAC_REG_PRE_LO, pre[7:0]);
    push_wr(`DAC_REG_PRE_HI, pre[15:8]);
    push_wr(`DAC_REG_CTR, `DAC_CTR_ENABLE);
    push_tx({dev, 1'b0}, `DAC_CR_STA | `DAC_CR_WR);
    push_tx(`DAC_POINTER, `DAC_CR_WR);
    if (rd) begin
        push_tx({dev, 1'b1}, `DAC_CR_STA | `DAC_CR_WR);   // repeated start, address with r
        push_wr(`DAC_REG_CR_SR, `DAC_CR_RD);
        push_wr(`DAC_REG_CR_SR, `DAC_CR_IACK);
        push_wr(`DAC_REG_CR_SR, `DAC_CR_RD | `DAC_CR_NACK | `DAC_CR_STO);
        push_wr(`DAC_REG_CR_SR, `DAC_CR_IACK);
    end else begin
        push_tx(word[15:8], `DAC_CR_WR);
        push_tx(word[7:0], `DAC_CR_STO | `DAC_CR_WR);
    end
endtask

task automatic start_job();
    if (in_job)
        report_failure("ack given while a job is in flight");
    if (iic_wr_ack_i && iic_rd_ack_i)
        report_failure("write and read ack in the same cycle");
    if (iic_wr_ack_i && !prev_wr_req)
        report_failure("write ack without a write request");
    if (iic_rd_ack_i && (!prev_rd_req || prev_wr_req))
        report_failure("read ack without a lone read request");
    name      = req_name_i;
    job_rd    = iic_rd_ack_i;
    rx_hi     = req_rx_hi_i;
    rx_lo     = req_rx_lo_i;
    tip       = int'(req_tip_i);
    wr_idx    = 0;
    sr_reads  = 0;
    rxr_reads = 0;
    build_expected(job_rd, device_addr_i, iic_wr_data_i);
    in_job    = 1'b1;
    started   = 1'b1;
endtask

task automatic check_access();
    if (!in_job) begin
        report_failure("wishbone access outside a job");
    end else if (wb_bus_i.we) begin
        if (wr_idx >= exp_len)
            report_mismatch("write count", exp_len, wr_idx + 1);
        else if (exp_wr[wr_idx] != {wb_bus_i.adr, wb_bus_i.dat})
            report_mismatch("register write", exp_wr[wr_idx], {wb_bus_i.adr, wb_bus_i.dat});
        wr_idx++;
    end else if (wb_bus_i.adr == `DAC_REG_CR_SR) begin
        sr_reads++;
    end else if (wb_bus_i.adr == `DAC_REG_TXR_RXR) begin
        rxr_reads++;
    end else begin
        report_failure("read from a register that the sequencer never reads");
    end
endtask

task automatic finish_job();
    if (!in_job) begin
        report_failure("done pulse without a job");
    end else begin
        if (iic_rd_done_i != job_rd || iic_wr_done_i == job_rd)
            report_failure("done pulse of the wrong kind");
        if (wr_idx != exp_len)
            report_mismatch("write count", exp_len, wr_idx);
        // every tx byte polls sr until tip clears
        if (sr_reads != (job_rd ? 3 : 4) * (tip + 1))
            report_mismatch("sr reads", (job_rd ? 3 : 4) * (tip + 1), sr_reads);
        if (rxr_reads != (job_rd ? 2 : 0))
            report_mismatch("rxr reads", job_rd ? 2 : 0, rxr_reads);
        if (job_rd) begin
            if (iic_rd_data_i !== {rx_hi, rx_lo})
                report_mismatch("read word", {rx_hi, rx_lo}, iic_rd_data_i);
            last_rd = iic_rd_data_i;
            have_rd = 1'b1;
        end
        done_cnt_o++;
    end
    in_job = 1'b0;
endtask

always @(posedge sys_clk) begin
    if (sys_rst) begin
        in_job      = 1'b0;
        started     = 1'b0;
        have_rd     = 1'b0;
        prev_wr_req = 1'b0;
        prev_rd_req = 1'b0;
        name        = req_name_i;
        err_cnt_o   = 0;
        done_cnt_o  = 0;
    end else begin
        if (iic_wr_ack_i || iic_rd_ack_i)
            start_job();
        if (!started && (iic_wr_done_i || iic_rd_done_i || iic_busy_i ||
                         wb_bus_i.cyc || wb_bus_i.stb))
            report_failure("host or bus activity before the first request");
        if (wb_bus_i.cyc && wb_bus_i.stb && wb_ack_i)
            check_access();
        if (iic_wr_done_i || iic_rd_done_i)
            finish_job();
        else if (have_rd && iic_rd_data_i !== last_rd)
            report_mismatch("held read word", last_rd, iic_rd_data_i);
        if (iic_busy_i !== in_job)
            report_mismatch("busy", in_job, iic_busy_i);
        prev_wr_req = iic_wr_req_i;
        prev_rd_req = iic_rd_req_i;
    end
end

endmodule

// ==== sim/tb_dac_cfg.sv ====
`timescale 1ns/10ps
`include "dac_cfg_config.svh"

module tb_dac_cfg import dac_cfg_pkg::*; ();

localparam int NUM_TESTS = 8;
localparam int LIMIT     = NUM_TESTS * 2000;

typedef struct packed {
    logic [63:0] name;
    logic        is_read;
    logic [6:0]  dev;
    logic [15:0] word;
    logic [7:0]  rx_hi;
    logic [7:0]  rx_lo;
    logic        rand_ack;   // random 0 to 5 cycle ack delay
    logic [3:0]  tip;        // sr reads with tip set for each tx byte
    logic        early;      // raised while the previous job is busy
} test_t;

test_t tbl [NUM_TESTS];

logic        sys_clk;
logic        sys_rst;
logic [6:0]  device_addr;
logic [15:0] iic_wr_data;
logic        iic_wr_req;
logic        iic_rd_req;
logic        iic_wr_ack;
logic        iic_rd_ack;
logic        iic_wr_done;
logic        iic_rd_done;
logic        iic_busy;
logic [15:0] iic_rd_data;
wb_bus_t     wb_bus;
logic [7:0]  wb_dat;
logic        wb_ack;
logic        wb_intr;

// attributes of the request on the host port
logic [63:0] req_name;
logic [7:0]  req_rx_hi;
logic [7:0]  req_rx_lo;
logic [3:0]  req_tip;
logic        req_rand;

// i2c core model state
logic        m_rand;
logic [3:0]  m_tip;
logic [7:0]  m_rx_hi;
logic [7:0]  m_rx_lo;
logic        in_access;
logic        rx_sel;     // next rxr read returns the low byte
int          ack_wait;
int          irq_cnt;
int          tip_left;
int          delay;

int          cycle_cnt;
int          tb_errs;
int          chk_errs;
int          chk_dones;
bit          pending;

dac_cfg_top u_dac_cfg_top (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .device_addr_i (device_addr),
    .iic_wr_data_i (iic_wr_data),
    .iic_wr_req_i  (iic_wr_req),
    .iic_rd_req_i  (iic_rd_req),
    .iic_wr_ack_o  (iic_wr_ack),
    .iic_rd_ack_o  (iic_rd_ack),
    .iic_wr_done_o (iic_wr_done),
    .iic_rd_done_o (iic_rd_done),
    .iic_busy_o    (iic_busy),
    .iic_rd_data_o (iic_rd_data),
    .wb_bus_o      (wb_bus),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack),
    .wb_intr_i     (wb_intr)
);

dac_cfg_checker u_dac_cfg_checker (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .req_name_i    (req_name),
    .req_rx_hi_i   (req_rx_hi),
    .req_rx_lo_i   (req_rx_lo),
    .req_tip_i     (req_tip),
    .device_addr_i (device_addr),
    .iic_wr_data_i (iic_wr_data),
    .iic_wr_req_i  (iic_wr_req),
    .iic_rd_req_i  (iic_rd_req),
    .iic_wr_ack_i  (iic_wr_ack),
    .iic_rd_ack_i  (iic_rd_ack),
    .iic_wr_done_i (iic_wr_done),
    .iic_rd_done_i (iic_rd_done),
    .iic_busy_i    (iic_busy),
    .iic_rd_data_i (iic_rd_data),
    .wb_bus_i      (wb_bus),
    .wb_ack_i      (wb_ack),
    .err_cnt_o     (chk_errs),
    .done_cnt_o    (chk_dones)
);

initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
end

task automatic load_table();
    //          name        rd    dev    word      rx_hi  rx_lo  rnd   tip   early
    tbl[0] = '{"wr_plain", 1'b0, 7'h0c, 16'h1234, 8'h00, 8'h00, 1'b0, 4'd0, 1'b0};
    tbl[1] = '{"rd_plain", 1'b1, 7'h0c, 16'h0000, 8'ha5, 8'h3c, 1'b0, 4'd0, 1'b0};
    tbl[2] = '{"wr_rnack", 1'b0, 7'h0d, 16'h0fed, 8'h00, 8'h00, 1'b1, 4'd0, 1'b0};
    tbl[3] = '{"rd_rnack", 1'b1, 7'h0d, 16'hffff, 8'h81, 8'h7e, 1'b1, 4'd0, 1'b0};
    tbl[4] = '{"wr_tip3x", 1'b0, 7'h0f, 16'h8001, 8'h00, 8'h00, 1'b1, 4'd3, 1'b0};
    tbl[5] = '{"rd_tip2x", 1'b1, 7'h0f, 16'h0000, 8'hff, 8'h00, 1'b1, 4'd2, 1'b0};
    tbl[6] = '{"wr_early", 1'b0, 7'h0c, 16'h5aa5, 8'h00, 8'h00, 1'b1, 4'd1, 1'b1};
    tbl[7] = '{"rd_early", 1'b1, 7'h0c, 16'h0000, 8'h12, 8'h34, 1'b0, 4'd0, 1'b1};
endtask

task automatic raise_request(input int idx);
    @(posedge sys_clk);
    device_addr <= tbl[idx].dev;
    iic_wr_data <= tbl[idx].word;
    iic_wr_req  <= ~tbl[idx].is_read;
    iic_rd_req  <= tbl[idx].is_read;
    req_name    <= tbl[idx].name;
    req_rx_hi   <= tbl[idx].rx_hi;
    req_rx_lo   <= tbl[idx].rx_lo;
    req_tip     <= tbl[idx].tip;
    req_rand    <= tbl[idx].rand_ack;
endtask

task automatic wait_for_ack();
    do
        @(posedge sys_clk);
    while (!(iic_wr_ack || iic_rd_ack));
    iic_wr_req <= 1'b0;
    iic_rd_req <= 1'b0;
endtask

task automatic wait_for_done();
    do
        @(posedge sys_clk);
    while (!(iic_wr_done || iic_rd_done));
endtask

// i2c master core register model
always @(posedge sys_clk) begin
    if (sys_rst) begin
        wb_ack    <= 1'b0;
        wb_intr   <= 1'b0;
        wb_dat    <= 8'h00;
        in_access <= 1'b0;
        rx_sel    <= 1'b0;
        ack_wait  <= 0;
        irq_cnt   <= 0;
        tip_left  <= 0;
        m_rand    <= 1'b0;
        m_tip     <= 4'd0;
        m_rx_hi   <= 8'h00;
        m_rx_lo   <= 8'h00;
    end else begin
        wb_ack <= 1'b0;
        if (iic_wr_ack || iic_rd_ack) begin   // parameters of the accepted job
            m_rand  <= req_rand;
            m_tip   <= req_tip;
            m_rx_hi <= req_rx_hi;
            m_rx_lo <= req_rx_lo;
        end
        if (irq_cnt != 0) begin
            irq_cnt <= irq_cnt - 1;
            if (irq_cnt == 1)
                wb_intr <= 1'b1;
        end
        if (wb_bus.cyc && wb_bus.stb && !wb_ack) begin
            delay = in_access ? ack_wait : (m_rand ? int'($urandom % 6) : 0);
            if (delay == 0) begin
                wb_ack    <= 1'b1;
                in_access <= 1'b0;
                if (wb_bus.we && wb_bus.adr == `DAC_REG_CR_SR) begin
                    if ((wb_bus.dat & (`DAC_CR_WR | `DAC_CR_RD)) != 8'h00) begin
                        irq_cnt  <= 3;          // byte done a few cycles later
                        tip_left <= int'(m_tip);
                        rx_sel   <= (wb_bus.dat & `DAC_CR_NACK) != 8'h00;
                    end
                    if ((wb_bus.dat & `DAC_CR_IACK) != 8'h00)
                        wb_intr <= 1'b0;
                end else if (!wb_bus.we && wb_bus.adr == `DAC_REG_CR_SR) begin
                    wb_dat <= (tip_left != 0) ? 8'h80 : 8'h00;
                    if (tip_left != 0)
                        tip_left <= tip_left - 1;
                end else if (!wb_bus.we && wb_bus.adr == `DAC_REG_TXR_RXR) begin
                    wb_dat <= rx_sel ? m_rx_lo : m_rx_hi;
                end
            end else begin
                ack_wait  <= delay - 1;
                in_access <= 1'b1;
            end
        end
    end
end

initial begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
        @(posedge sys_clk);
        cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("TESTS FAILED");
    $finish;
end

initial begin
    void'($urandom(17254));
    load_table();
    sys_rst     = 1'b1;
    device_addr = 7'h00;
    iic_wr_data = 16'h0000;
    iic_wr_req  = 1'b0;
    iic_rd_req  = 1'b0;
    wb_dat      = 8'h00;
    wb_ack      = 1'b0;
    wb_intr     = 1'b0;
    req_name    = "post_rst";
    req_rx_hi   = 8'h00;
    req_rx_lo   = 8'h00;
    req_tip     = 4'd0;
    req_rand    = 1'b0;
    tb_errs     = 0;
    pending     = 1'b0;
    repeat (10) @(posedge sys_clk);
    sys_rst <= 1'b0;
    repeat (5) @(posedge sys_clk);     // idle window before the first request

    for (int i = 0; i < NUM_TESTS; i++) begin
        if (!pending)
            raise_request(i);
        wait_for_ack();
        pending = 1'b0;
        if (i + 1 < NUM_TESTS && tbl[i + 1].early) begin
            repeat (4) @(posedge sys_clk);
            raise_request(i + 1);      // must wait for this job's done
            pending = 1'b1;
        end
        wait_for_done();
        if (!pending)
            repeat (3) @(posedge sys_clk);
    end

    repeat (5) @(posedge sys_clk);
    if (chk_dones != NUM_TESTS) begin
        $display("only %0d of %0d jobs completed", chk_dones, NUM_TESTS);
        tb_errs++;
    end
    $display("errors: %0d checker, %0d testbench", chk_errs, tb_errs);
    if (chk_errs == 0 && tb_errs == 0)
        $display("TESTS PASSED");
    else
        $display("TESTS FAILED");
    $finish;
end

endmodule

// ==== sources.f ====
+incdir+common
common/dac_cfg_pkg.sv
hw/cfg_request_ctrl.sv
dac_seq/dac_seq_fsm.sv
hw/wb_reg_master.sv
hw/dac_cfg_top.sv
sim/dac_cfg_checker.sv
sim/tb_dac_cfg.sv
